//--- Bender.yml
package:
  name: ex_stage

sources:
  - verilog/ex_pkg.sv
  - verilog/ex_decode.sv
  - verilog/ex_alu.sv
  - verilog/ex_mult.sv
  - verilog/ex_result.sv
  - verilog/ex_stage.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/ex_stage_tb.sv

//--- bench/ex_stage_tasks.svh
// Directed tests and reference models of the execute stage, included into the testbench top
`ifndef EX_STAGE_TASKS_SVH
`define EX_STAGE_TASKS_SVH

//////////////////////////////////////////////////
// Reference models
//////////////////////////////////////////////////

// Less-than, signed or unsigned
function automatic logic less_model(logic [31:0] a, logic [31:0] b, logic signed_cmp);
  // Differing signs settle a signed compare alone
  if (signed_cmp && (a[31] != b[31])) begin
    return a[31];
  end
  return a < b;
endfunction

// Branch and set-less-than flag
function automatic logic cmp_model(ex_pkg::alu_op_e op, logic [31:0] a, logic [31:0] b);
  case (op)
    ex_pkg::alu_eq:   return a == b;
    ex_pkg::alu_ne:   return a != b;
    ex_pkg::alu_slt,
    ex_pkg::alu_lt:   return less_model(a, b, 1'b1);
    ex_pkg::alu_ge:   return !less_model(a, b, 1'b1);
    ex_pkg::alu_sltu,
    ex_pkg::alu_ltu:  return less_model(a, b, 1'b0);
    ex_pkg::alu_geu:  return !less_model(a, b, 1'b0);
    default:          return 1'b0;
  endcase
endfunction

function automatic logic [31:0] alu_model(ex_pkg::alu_op_e op, logic [31:0] a, logic [31:0] b);
  logic [63:0] sext;
  // Sign copies above a feed the arithmetic shift
  sext = {{32{a[31]}}, a};
  case (op)
    ex_pkg::alu_add: return a + b;
    ex_pkg::alu_sub: return a - b;
    ex_pkg::alu_and: return a & b;
    ex_pkg::alu_or:  return a | b;
    ex_pkg::alu_xor: return a ^ b;
    ex_pkg::alu_sll: return a << b[4:0];
    ex_pkg::alu_srl: return a >> b[4:0];
    ex_pkg::alu_sra: begin
      sext = sext >> b[4:0];
      return sext[31:0];
    end
    default:         return {31'b0, cmp_model(op, a, b)};
  endcase
endfunction

// RISC-V multiply, 64-bit product of the extended operands
function automatic logic [31:0] mult_model(ex_pkg::mult_op_e op, logic [31:0] a, logic [31:0] b);
  logic [63:0] ext_a;
  logic [63:0] ext_b;
  logic [63:0] prod;
  ext_a = {32'b0, a};
  ext_b = {32'b0, b};
  if (op == ex_pkg::mult_mulh || op == ex_pkg::mult_mulhsu) begin
    ext_a = {{32{a[31]}}, a};
  end
  if (op == ex_pkg::mult_mulh) begin
    ext_b = {{32{b[31]}}, b};
  end
  prod = ext_a * ext_b;
  if (op == ex_pkg::mult_mul) begin
    return prod[31:0];
  end
  return prod[63:32];
endfunction

//////////////////////////////////////////////////
// Drive and compare
//////////////////////////////////////////////////

task automatic check_word(string test, logic [31:0] expected, logic [31:0] actual);
  checks++;
  if (actual !== expected) begin
    errors++;
    $display("mismatch %s: expected %h, actual %h", test, expected, actual);
  end
endtask

task automatic check_bit(string test, logic expected, logic actual);
  checks++;
  if (actual !== expected) begin
    errors++;
    $display("mismatch %s: expected %b, actual %b", test, expected, actual);
  end
endtask

// New inputs at the rising edge, outputs settled by the falling edge
task automatic drive_cycle(ex_pkg::ex_req_t r, logic wb_rdy, logic err);
  @(posedge clk);
  req       <= r;
  wb_ready  <= wb_rdy;
  lsu_err   <= err;
  lsu_rdata <= $urandom();
  @(negedge clk);
endtask

// One more cycle with the inputs held
task automatic hold_cycle();
  @(posedge clk);
  @(negedge clk);
endtask

//////////////////////////////////////////////////
// Tests
//////////////////////////////////////////////////

task automatic test_alu_ops();
  ex_pkg::ex_req_t r;
  logic [31:0]     rnd;
  string           name;
  int              i;
  for (i = 0; i < 16; i++) begin
    rnd         = $urandom();
    r           = '0;
    r.alu_en    = 1'b1;
    r.alu_we    = rnd[31];
    r.alu_waddr = rnd[5:0];
    r.alu_op    = ex_pkg::alu_op_e'(i[4:0]);
    r.operand_a = $urandom();
    r.operand_b = $urandom();
    name        = $sformatf("alu op %0d", i);
    drive_cycle(r, 1'b1, 1'b0);
    check_word(name, alu_model(r.alu_op, r.operand_a, r.operand_b), fw_port.wdata);
    check_bit({name, " we"}, r.alu_we, fw_port.we);
    check_word({name, " waddr"}, {26'b0, r.alu_waddr}, {26'b0, fw_port.waddr});
    check_bit({name, " valid"}, 1'b1, ex_valid);
  end
endtask

task automatic test_branches();
  ex_pkg::ex_req_t r;
  logic [31:0]     pair_a [4];
  logic [31:0]     pair_b [4];
  string           name;
  int              i;
  int              p;
  // Equal, signed less, signed greater, plain less
  pair_a = '{32'h0000_0005, 32'hffff_fffd, 32'h0000_0007, 32'h0000_0003};
  pair_b = '{32'h0000_0005, 32'h0000_0007, 32'hffff_fffd, 32'h0000_0009};
  for (i = 10; i < 16; i++) begin
    for (p = 0; p < 4; p++) begin
      r              = '0;
      r.branch_in_ex = 1'b1;
      r.alu_op       = ex_pkg::alu_op_e'(i[4:0]);
      r.operand_a    = pair_a[p];
      r.operand_b    = pair_b[p];
      r.operand_c    = $urandom();
      name           = $sformatf("branch op %0d pair %0d", i, p);
      // WB stalled, branch must still release ID
      drive_cycle(r, 1'b0, 1'b0);
      check_bit(name, cmp_model(r.alu_op, r.operand_a, r.operand_b), branch_decision);
      check_word({name, " target"}, r.operand_c, jump_target);
      check_bit({name, " ready"}, 1'b1, ex_ready);
    end
  end
endtask

task automatic test_mult();
  ex_pkg::ex_req_t r;
  string           name;
  int              i;
  int              k;
  for (i = 0; i < 4; i++) begin
    for (k = 0; k < 4; k++) begin
      r           = '0;
      r.mult_en   = 1'b1;
      r.alu_we    = 1'b1;
      r.mult_op   = ex_pkg::mult_op_e'(i[1:0]);
      r.operand_a = $urandom();
      r.operand_b = $urandom();
      // Corner signs on the first two pairs
      if (k == 0) begin
        r.operand_a = 32'h8000_0000;
        r.operand_b = 32'hffff_ffff;
      end else if (k == 1) begin
        r.operand_a = 32'hffff_fffe;
        r.operand_b = 32'h7fff_ffff;
      end
      name = $sformatf("mult op %0d case %0d", i, k);
      drive_cycle(r, 1'b1, 1'b0);
      if (i != 0) begin
        // High part, first cycle busy
        check_bit({name, " first valid"}, 1'b0, ex_valid);
        check_bit({name, " first multicycle"}, 1'b0, mult_multicycle);
        check_bit({name, " first ready"}, 1'b0, ex_ready);
        hold_cycle();
      end
      check_word(name, mult_model(r.mult_op, r.operand_a, r.operand_b), fw_port.wdata);
      check_bit({name, " valid"}, 1'b1, ex_valid);
      check_bit({name, " multicycle"}, (i != 0), mult_multicycle);
    end
  end
endtask

task automatic test_csr();
  ex_pkg::ex_req_t r;
  logic [31:0]     rnd;
  int              i;
  for (i = 0; i < 3; i++) begin
    rnd          = $urandom();
    r            = '0;
    r.csr_access = 1'b1;
    r.alu_we     = 1'b1;
    r.alu_waddr  = rnd[5:0];
    r.alu_op     = ex_pkg::alu_add;
    r.operand_a  = $urandom();
    r.csr_rdata  = $urandom();
    drive_cycle(r, 1'b1, 1'b0);
    check_word("csr data", r.csr_rdata, fw_port.wdata);
    check_word("csr waddr", {26'b0, r.alu_waddr}, {26'b0, fw_port.waddr});
    check_bit("csr valid", 1'b1, ex_valid);
  end
endtask

task automatic test_lsu_port();
  ex_pkg::ex_req_t r;
  logic [31:0]     rnd;
  rnd         = $urandom();
  r           = '0;
  r.lsu_en    = 1'b1;
  r.lsu_we    = 1'b1;
  r.lsu_waddr = rnd[5:0];
  drive_cycle(r, 1'b1, 1'b0);
  check_bit("lsu valid", 1'b1, ex_valid);
  drive_cycle('0, 1'b1, 1'b0);
  check_bit("lsu we", 1'b1, wb_port.we);
  check_word("lsu waddr", {26'b0, r.lsu_waddr}, {26'b0, wb_port.waddr});
  check_word("lsu wdata", lsu_rdata, wb_port.wdata);
  // Empty cycle drains the register
  drive_cycle('0, 1'b1, 1'b0);
  check_bit("lsu drain", 1'b0, wb_port.we);
  // Bus error blocks the write
  drive_cycle(r, 1'b1, 1'b1);
  drive_cycle('0, 1'b1, 1'b0);
  check_bit("lsu error", 1'b0, wb_port.we);
endtask

task automatic test_backpressure();
  ex_pkg::ex_req_t r;
  ex_pkg::ex_req_t m;
  logic [31:0]     rnd;
  int              i;
  rnd         = $urandom();
  r           = '0;
  r.lsu_en    = 1'b1;
  r.lsu_we    = 1'b1;
  r.lsu_waddr = rnd[5:0];
  m           = '0;
  m.mult_en   = 1'b1;
  m.alu_we    = 1'b1;
  m.mult_op   = ex_pkg::mult_mulh;
  m.operand_a = $urandom();
  m.operand_b = $urandom();
  drive_cycle(r, 1'b1, 1'b0);
  // mulh issued while WB stalls
  drive_cycle(m, 1'b0, 1'b0);
  check_bit("stall first valid", 1'b0, ex_valid);
  check_bit("stall first ready", 1'b0, ex_ready);
  for (i = 0; i < 3; i++) begin
    hold_cycle();
    check_bit("stall valid", 1'b0, ex_valid);
    check_bit("stall ready", 1'b0, ex_ready);
    check_bit("stall multicycle", 1'b1, mult_multicycle);
    check_bit("stall wb we", 1'b1, wb_port.we);
    check_word("stall wb waddr", {26'b0, r.lsu_waddr}, {26'b0, wb_port.waddr});
  end
  // WB free again, product released
  drive_cycle(m, 1'b1, 1'b0);
  check_bit("release valid", 1'b1, ex_valid);
  check_bit("release ready", 1'b1, ex_ready);
  check_word("release product", mult_model(m.mult_op, m.operand_a, m.operand_b), fw_port.wdata);
  check_bit("release wb we", 1'b1, wb_port.we);
endtask

`endif

//--- bench/ex_stage_tb.sv
// Testbench top for the execute stage, runs the directed tests and prints the closing report
module ex_stage_tb;

  // Whole run is far shorter than this
  localparam int max_cycles = 2000;

  logic                    clk;
  logic                    rst_n;
  ex_pkg::ex_req_t         req;
  logic [ex_pkg::xlen-1:0] lsu_rdata;
  logic                    lsu_ready_ex;
  logic                    lsu_err;
  logic                    wb_ready;
  ex_pkg::wport_t          fw_port;
  ex_pkg::wport_t          wb_port;
  logic                    branch_decision;
  logic [ex_pkg::xlen-1:0] jump_target;
  logic                    mult_multicycle;
  logic                    ex_ready;
  logic                    ex_valid;

  // Scoreboard counters
  int checks;
  int errors;
  int cycles;

  `include "ex_stage_tasks.svh"

  ex_stage u_ex_stage (
    .clk               (clk),
    .rst_n             (rst_n),
    .req_i             (req),
    .lsu_rdata_i       (lsu_rdata),
    .lsu_ready_ex_i    (lsu_ready_ex),
    .lsu_err_i         (lsu_err),
    .wb_ready_i        (wb_ready),
    .fw_port_o         (fw_port),
    .wb_port_o         (wb_port),
    .branch_decision_o (branch_decision),
    .jump_target_o     (jump_target),
    .mult_multicycle_o (mult_multicycle),
    .ex_ready_o        (ex_ready),
    .ex_valid_o        (ex_valid)
  );

  //////////////////////////////////////////////////
  // Clock and watchdog
  //////////////////////////////////////////////////

  // Period 4
  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= max_cycles) begin
      $display("timeout, the test sequence did not finish within %0d cycles", max_cycles);
      $display("Result: FAILED");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin
    void'($urandom(32'h2d2e5758));
    clk          = 1'b0;
    rst_n        = 1'b0;
    req          = '0;
    lsu_rdata    = '0;
    lsu_ready_ex = 1'b1;
    lsu_err      = 1'b0;
    wb_ready     = 1'b1;
    checks       = 0;
    errors       = 0;
    cycles       = 0;
    // Reset held for 5 cycles
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    test_alu_ops();
    test_branches();
    test_mult();
    test_csr();
    test_lsu_port();
    test_backpressure();
    drive_cycle('0, 1'b1, 1'b0);
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

//--- verilog.f
+incdir+bench
verilog/ex_pkg.sv
verilog/ex_decode.sv
verilog/ex_alu.sv
verilog/ex_mult.sv
verilog/ex_result.sv
verilog/ex_stage.sv
bench/ex_stage_tb.sv

//--- verilog/ex_alu.sv
// Single-cycle integer ALU of the execute stage, with a compare flag for branches
module ex_alu (
  input  ex_pkg::alu_op_e          alu_op_i,
  input  logic [ex_pkg::xlen-1:0]  operand_a_i,
  input  logic [ex_pkg::xlen-1:0]  operand_b_i,
  output logic [ex_pkg::xlen-1:0]  result_o,
  output logic                     cmp_result_o
);

  // Shift amount, low bits of b only
  logic [4:0] shamt;
  // Raw comparisons
  logic       eq;
  logic       lt_s;
  logic       lt_u;
  // Compare result of the current operator
  logic       cmp;

  assign shamt = operand_b_i[4:0];
  assign eq    = (operand_a_i == operand_b_i);
  assign lt_s  = ($signed(operand_a_i) < $signed(operand_b_i));
  assign lt_u  = (operand_a_i < operand_b_i);

  //////////////////////////////////////////////////
  // Compare
  //////////////////////////////////////////////////

  always_comb begin
    cmp = 1'b0;
    case (alu_op_i)
      ex_pkg::alu_eq:   cmp = eq;
      ex_pkg::alu_ne:   cmp = ~eq;
      // slt shares the signed compare with blt
      ex_pkg::alu_slt,
      ex_pkg::alu_lt:   cmp = lt_s;
      ex_pkg::alu_ge:   cmp = ~lt_s;
      ex_pkg::alu_sltu,
      ex_pkg::alu_ltu:  cmp = lt_u;
      ex_pkg::alu_geu:  cmp = ~lt_u;
      default:          cmp = 1'b0;
    endcase
  end

  //////////////////////////////////////////////////
  // Result
  //////////////////////////////////////////////////

  always_comb begin
    case (alu_op_i)
      ex_pkg::alu_add: result_o = operand_a_i + operand_b_i;
      ex_pkg::alu_sub: result_o = operand_a_i - operand_b_i;
      ex_pkg::alu_and: result_o = operand_a_i & operand_b_i;
      ex_pkg::alu_or:  result_o = operand_a_i | operand_b_i;
      ex_pkg::alu_xor: result_o = operand_a_i ^ operand_b_i;
      ex_pkg::alu_sll: result_o = operand_a_i << shamt;
      ex_pkg::alu_srl: result_o = operand_a_i >> shamt;
      // Arithmetic shift keeps the sign
      ex_pkg::alu_sra: result_o = $unsigned($signed(operand_a_i) >>> shamt);
      // Compares, zero-extended flag
      default:         result_o = {{(ex_pkg::xlen-1){1'b0}}, cmp};
    endcase
  end

  // Branch unit sees the same flag
  assign cmp_result_o = cmp;

endmodule

//--- verilog/ex_decode.sv
// Execute stage control, picks the forwarding source and forms the ready and valid levels
module ex_decode (
  input  logic             clk,
  input  logic             rst_n,
  input  ex_pkg::ex_req_t  req_i,
  input  logic             alu_ready_i,
  input  logic             mult_ready_i,
  input  logic             lsu_ready_ex_i,
  input  logic             wb_ready_i,
  output ex_pkg::fw_src_e  fw_src_o,
  output logic             ex_ready_o,
  output logic             ex_valid_o
);

  // All units and the WB stage can take a new request
  logic units_ready;
  // Some unit has work this cycle
  logic any_en;

  //////////////////////////////////////////////////
  // Forwarding source
  //////////////////////////////////////////////////

  // Priority csr over mult over alu
  always_comb begin
    fw_src_o = ex_pkg::fw_alu;
    if (req_i.mult_en) begin
      fw_src_o = ex_pkg::fw_mult;
    end
    if (req_i.csr_access) begin
      fw_src_o = ex_pkg::fw_csr;
    end
  end

  //////////////////////////////////////////////////
  // Stall levels
  //////////////////////////////////////////////////

  assign units_ready = alu_ready_i & mult_ready_i & lsu_ready_ex_i & wb_ready_i;
  assign any_en      = req_i.alu_en | req_i.mult_en | req_i.csr_access | req_i.lsu_en;

  // Branches resolve here and never wait for WB
  assign ex_ready_o = units_ready | req_i.branch_in_ex;
  // Valid moves right and does not look at ex_ready
  assign ex_valid_o = any_en & units_ready;

  // ID issues to one result unit at a time
  a_one_unit : assert property (
    @(posedge clk) disable iff (!rst_n)
    $onehot0({req_i.alu_en, req_i.mult_en, req_i.csr_access})
  ) else $error("ex_decode: more than one unit enabled");

endmodule

//--- verilog/ex_mult.sv
// Integer multiplier of the execute stage, low product in one cycle, high product in two
module ex_mult (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     enable_i,
  input  ex_pkg::mult_op_e         mult_op_i,
  input  logic [ex_pkg::xlen-1:0]  operand_a_i,
  input  logic [ex_pkg::xlen-1:0]  operand_b_i,
  input  logic                     ex_ready_i,
  output logic [ex_pkg::xlen-1:0]  result_o,
  output logic                     ready_o,
  output logic                     multicycle_o
);

  typedef enum logic {
    st_idle,
    st_high
  } mult_state_e;

  mult_state_e state_q;
  mult_state_e state_d;

  // Operands widened by one bit for signed or unsigned use
  logic signed [ex_pkg::xlen:0]       op_a_ext;
  logic signed [ex_pkg::xlen:0]       op_b_ext;
  logic signed [2*ex_pkg::xlen+1:0]   prod_full;
  // Request for a high part
  logic                               high_op;
  // First cycle of a high part
  logic                               high_start;
  // High half held for the second cycle
  logic [ex_pkg::xlen-1:0]            high_q;

  assign high_op    = (mult_op_i != ex_pkg::mult_mul);
  assign high_start = (state_q == st_idle) & enable_i & high_op;

  //////////////////////////////////////////////////
  // Product
  //////////////////////////////////////////////////

  // mulh signs both, mulhsu only a, mulhu neither
  always_comb begin
    op_a_ext = {1'b0, operand_a_i};
    op_b_ext = {1'b0, operand_b_i};
    if (mult_op_i == ex_pkg::mult_mulh || mult_op_i == ex_pkg::mult_mulhsu) begin
      op_a_ext = {operand_a_i[ex_pkg::xlen-1], operand_a_i};
    end
    if (mult_op_i == ex_pkg::mult_mulh) begin
      op_b_ext = {operand_b_i[ex_pkg::xlen-1], operand_b_i};
    end
  end

  // Low half is the same for every extension
  assign prod_full = op_a_ext * op_b_ext;

  always_ff @(posedge clk) begin
    if (high_start) begin
      high_q <= prod_full[2*ex_pkg::xlen-1:ex_pkg::xlen];
    end
  end

  //////////////////////////////////////////////////
  // Control FSM
  //////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      st_idle: if (high_start) state_d = st_high;
      // Stay put while the stage is stalled
      st_high: if (ex_ready_i) state_d = st_idle;
      default: state_d = st_idle;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= st_idle;
    end else begin
      state_q <= state_d;
    end
  end

  // Busy only in the first cycle of a high part
  assign ready_o      = ~high_start;
  assign multicycle_o = (state_q == st_high);
  assign result_o     = (state_q == st_high) ? high_q : prod_full[ex_pkg::xlen-1:0];

  // ID must hold the request until the high part is taken
  a_hold_req : assert property (
    @(posedge clk) disable iff (!rst_n)
    (state_q == st_high) |->
      $stable(mult_op_i) && $stable(operand_a_i) && $stable(operand_b_i)
  ) else $error("ex_mult: request changed during high part");

endmodule

//--- verilog/ex_pkg.sv
// Shared widths, operator codes and port structs of the execute stage; compile before all RTL
package ex_pkg;

  //////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////

  // Data word
  localparam int unsigned xlen = 32;
  // Register address, room for 64 registers
  localparam int unsigned reg_addr_w = 6;

  //////////////////////////////////////////////////
  // Operator codes
  //////////////////////////////////////////////////

  // ALU operators, compares at the top of the range
  typedef enum logic [4:0] {
    alu_add, alu_sub, alu_and, alu_or, alu_xor,
    alu_sll, alu_srl, alu_sra,
    alu_slt, alu_sltu,
    alu_eq, alu_ne, alu_lt, alu_ge, alu_ltu, alu_geu
  } alu_op_e;

  // Multiplier operators, all but mul take two cycles
  typedef enum logic [1:0] {
    mult_mul, mult_mulh, mult_mulhsu, mult_mulhu
  } mult_op_e;

  // Source of the forwarding write data
  typedef enum logic [1:0] {
    fw_alu, fw_mult, fw_csr
  } fw_src_e;

  //////////////////////////////////////////////////
  // Port structs
  //////////////////////////////////////////////////

  // One instruction from ID
  typedef struct packed {
    logic                  alu_en;
    logic                  mult_en;
    logic                  csr_access;
    logic                  lsu_en;
    logic                  branch_in_ex;
    alu_op_e               alu_op;
    mult_op_e              mult_op;
    logic [xlen-1:0]       operand_a;
    logic [xlen-1:0]       operand_b;
    // Jump target for branches
    logic [xlen-1:0]       operand_c;
    logic [xlen-1:0]       csr_rdata;
    logic [reg_addr_w-1:0] alu_waddr;
    logic                  alu_we;
    logic [reg_addr_w-1:0] lsu_waddr;
    logic                  lsu_we;
  } ex_req_t;

  // Register file write port, forwarding and LSU write-back
  typedef struct packed {
    logic                  we;
    logic [reg_addr_w-1:0] waddr;
    logic [xlen-1:0]       wdata;
  } wport_t;

endpackage

//--- verilog/ex_result.sv
// Forwarding write-port mux and EX/WB register for the LSU write-back port
module ex_result (
  input  logic                     clk,
  input  logic                     rst_n,
  input  ex_pkg::ex_req_t          req_i,
  input  ex_pkg::fw_src_e          fw_src_i,
  input  logic [ex_pkg::xlen-1:0]  alu_result_i,
  input  logic [ex_pkg::xlen-1:0]  mult_result_i,
  input  logic                     ex_valid_i,
  input  logic                     wb_ready_i,
  input  logic                     lsu_err_i,
  input  logic [ex_pkg::xlen-1:0]  lsu_rdata_i,
  output ex_pkg::wport_t           fw_port_o,
  output ex_pkg::wport_t           wb_port_o
);

  // LSU write that survives a bus error
  logic                          lsu_wr;
  logic                          wb_we_q;
  logic [ex_pkg::reg_addr_w-1:0] wb_waddr_q;

  //////////////////////////////////////////////////
  // Forwarding port
  //////////////////////////////////////////////////

  always_comb begin
    fw_port_o.we    = req_i.alu_we;
    fw_port_o.waddr = req_i.alu_waddr;
    case (fw_src_i)
      ex_pkg::fw_mult: fw_port_o.wdata = mult_result_i;
      ex_pkg::fw_csr:  fw_port_o.wdata = req_i.csr_rdata;
      default:         fw_port_o.wdata = alu_result_i;
    endcase
  end

  //////////////////////////////////////////////////
  // EX/WB register
  //////////////////////////////////////////////////

  assign lsu_wr = req_i.lsu_we & ~lsu_err_i;

  // Valid implies WB is ready
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_we_q <= 1'b0;
    end else if (ex_valid_i) begin
      wb_we_q <= lsu_wr;
    end else if (wb_ready_i) begin
      // No new instruction, drain the old one
      wb_we_q <= 1'b0;
    end
  end

  // Address only moves with a real write
  always_ff @(posedge clk) begin
    if (ex_valid_i && lsu_wr) begin
      wb_waddr_q <= req_i.lsu_waddr;
    end
  end

  always_comb begin
    wb_port_o.we    = wb_we_q;
    wb_port_o.waddr = wb_waddr_q;
    // Load data arrives straight from the LSU
    wb_port_o.wdata = lsu_rdata_i;
  end

  // A faulting load never reaches the register file
  a_no_err_write : assert property (
    @(posedge clk) disable iff (!rst_n)
    $rose(wb_port_o.we) |-> !$past(lsu_err_i)
  ) else $error("ex_result: LSU write enabled after bus error");

endmodule

//--- verilog/ex_stage.sv
// Execute stage top level, connects control, ALU, multiplier and result path
module ex_stage (
  input  logic                     clk,
  input  logic                     rst_n,
  input  ex_pkg::ex_req_t          req_i,
  input  logic [ex_pkg::xlen-1:0]  lsu_rdata_i,
  input  logic                     lsu_ready_ex_i,
  input  logic                     lsu_err_i,
  input  logic                     wb_ready_i,
  output ex_pkg::wport_t           fw_port_o,
  output ex_pkg::wport_t           wb_port_o,
  output logic                     branch_decision_o,
  output logic [ex_pkg::xlen-1:0]  jump_target_o,
  output logic                     mult_multicycle_o,
  output logic                     ex_ready_o,
  output logic                     ex_valid_o
);

  logic [ex_pkg::xlen-1:0] alu_result;
  logic                    alu_cmp;
  logic [ex_pkg::xlen-1:0] mult_result;
  logic                    mult_ready;
  ex_pkg::fw_src_e         fw_src;

  // ALU never stalls
  ex_decode u_ex_decode (
    .clk            (clk),
    .rst_n          (rst_n),
    .req_i          (req_i),
    .alu_ready_i    (1'b1),
    .mult_ready_i   (mult_ready),
    .lsu_ready_ex_i (lsu_ready_ex_i),
    .wb_ready_i     (wb_ready_i),
    .fw_src_o       (fw_src),
    .ex_ready_o     (ex_ready_o),
    .ex_valid_o     (ex_valid_o)
  );

  ex_alu u_ex_alu (
    .alu_op_i     (req_i.alu_op),
    .operand_a_i  (req_i.operand_a),
    .operand_b_i  (req_i.operand_b),
    .result_o     (alu_result),
    .cmp_result_o (alu_cmp)
  );

  // ex_ready releases the high part
  ex_mult u_ex_mult (
    .clk          (clk),
    .rst_n        (rst_n),
    .enable_i     (req_i.mult_en),
    .mult_op_i    (req_i.mult_op),
    .operand_a_i  (req_i.operand_a),
    .operand_b_i  (req_i.operand_b),
    .ex_ready_i   (ex_ready_o),
    .result_o     (mult_result),
    .ready_o      (mult_ready),
    .multicycle_o (mult_multicycle_o)
  );

  ex_result u_ex_result (
    .clk           (clk),
    .rst_n         (rst_n),
    .req_i         (req_i),
    .fw_src_i      (fw_src),
    .alu_result_i  (alu_result),
    .mult_result_i (mult_result),
    .ex_valid_i    (ex_valid_o),
    .wb_ready_i    (wb_ready_i),
    .lsu_err_i     (lsu_err_i),
    .lsu_rdata_i   (lsu_rdata_i),
    .fw_port_o     (fw_port_o),
    .wb_port_o     (wb_port_o)
  );

  // Branch outcome to IF
  assign branch_decision_o = alu_cmp;
  assign jump_target_o     = req_i.operand_c;

endmodule
